// ==== Makefile ====
# Verilator build and run for the openmips testbench.

VERILATOR ?= verilator
TOP       ?= tb_openmips
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Pass or fail comes from the simulator output itself.
run: build
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
+incdir+verilog
verilog/openmips_pkg.sv
verilog/pc_reg.sv
verilog/id.sv
verilog/regfile.sv
verilog/ex.sv
verilog/mem_wb.sv
verilog/openmips.sv
testbench/tb_openmips.sv

// ==== testbench/tb_openmips.sv ====
`timescale 1ns/1ps
`include "openmips_consts.svh"

module tb_openmips;

  localparam int MEM_WORDS   = 256;
  localparam int RUN_TIMEOUT = MEM_WORDS + 40;

  logic              clk = 1'b0;
  logic              rst_i;
  logic [31:0]       inst_i;
  logic              ce_o;
  logic [31:0]       addr_o;
  openmips_pkg::wb_t commit_o;

  logic [31:0]       prog_mem [0:255];
  logic [8:0]        fill_count = 9'd0;
  logic [31:0]       model_regs [0:31];
  openmips_pkg::wb_t exp_q [$];
  int                due_q [$];  // Cycle in which each expected commit is due.
  integer            seed;
  int                cycle = 0;
  int                retired = 0;
  logic              prev_ce = 1'b0;
  logic [31:0]       prev_addr = 32'd0;

  openmips uut (
    .clk      (clk),
    .rst_i    (rst_i),
    .inst_i   (inst_i),
    .ce_o     (ce_o),
    .addr_o   (addr_o),
    .commit_o (commit_o)
  );

  // Program memory, word addressed. Fetches past the end see a nop.
  assign inst_i = (addr_o[31:10] == 22'd0) ? prog_mem[addr_o[9:2]] : 32'd0;

  initial begin
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at time %0t: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encode_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [4:0] sh,
                                               input logic [5:0] fn);
    return {`OP_SPECIAL, rs, rt, rd, sh, fn};
  endfunction

  task automatic append_inst(input logic [31:0] word);
    prog_mem[fill_count[7:0]] = word;
    fill_count = fill_count + 9'd1;
  endtask

  // Registers r0..r7 only, so that random code is full of dependencies.
  function automatic logic [31:0] random_inst();
    logic [31:0] pick;
    logic [31:0] bits;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sh;
    pick = $unsigned($random(seed)) % 32'd15;
    bits = $random(seed);
    rs   = {2'b00, bits[2:0]};
    rt   = {2'b00, bits[5:3]};
    rd   = {2'b00, bits[8:6]};
    sh   = bits[13:9];
    case (pick)
      0:       return encode_itype(`OP_ORI, rs, rt, bits[31:16]);
      1:       return encode_itype(`OP_ANDI, rs, rt, bits[31:16]);
      2:       return encode_itype(`OP_XORI, rs, rt, bits[31:16]);
      3:       return encode_itype(`OP_LUI, 5'd0, rt, bits[31:16]);
      4:       return encode_itype(`OP_ADDIU, rs, rt, bits[31:16]);
      5:       return encode_rtype(rs, rt, rd, 5'd0, `FN_AND);
      6:       return encode_rtype(rs, rt, rd, 5'd0, `FN_OR);
      7:       return encode_rtype(rs, rt, rd, 5'd0, `FN_XOR);
      8:       return encode_rtype(rs, rt, rd, 5'd0, `FN_NOR);
      9:       return encode_rtype(rs, rt, rd, 5'd0, `FN_ADDU);
      10:      return encode_rtype(rs, rt, rd, 5'd0, `FN_SUBU);
      11:      return encode_rtype(rs, rt, rd, 5'd0, `FN_SLT);
      12:      return encode_rtype(5'd0, rt, rd, sh, `FN_SLL);
      13:      return encode_rtype(5'd0, rt, rd, sh, `FN_SRL);
      default: return encode_rtype(5'd0, rt, rd, sh, `FN_SRA);
    endcase
  endfunction

  task automatic load_program();
    // Immediates, then readers of r1 at distances 1, 2 and 3.
    append_inst(encode_itype(`OP_ORI, 5'd0, 5'd1, 16'h1234));
    append_inst(encode_itype(`OP_ORI, 5'd1, 5'd2, 16'h00f0));
    append_inst(encode_itype(`OP_ANDI, 5'd1, 5'd3, 16'hff00));
    append_inst(encode_itype(`OP_XORI, 5'd1, 5'd4, 16'hffff));
    append_inst(encode_itype(`OP_LUI, 5'd0, 5'd5, 16'h8000));
    append_inst(encode_itype(`OP_ADDIU, 5'd5, 5'd6, 16'hffff));  // Adds -1.
    append_inst(encode_itype(`OP_ADDIU, 5'd0, 5'd7, 16'h8000));
    append_inst(encode_itype(`OP_ADDIU, 5'd7, 5'd8, 16'h7fff));
    append_inst(encode_rtype(5'd0, 5'd6, 5'd9, 5'd0, `FN_SUBU));
    append_inst(encode_rtype(5'd7, 5'd1, 5'd10, 5'd0, `FN_SLT));  // Negative below positive.
    append_inst(encode_rtype(5'd1, 5'd7, 5'd11, 5'd0, `FN_SLT));
    append_inst(encode_rtype(5'd0, 5'd5, 5'd12, 5'd4, `FN_SRA));
    append_inst(encode_rtype(5'd0, 5'd5, 5'd13, 5'd4, `FN_SRL));
    append_inst(encode_rtype(5'd0, 5'd1, 5'd14, 5'd8, `FN_SLL));
    append_inst(encode_rtype(5'd1, 5'd2, 5'd15, 5'd0, `FN_NOR));
    // A write to r0 commits, yet its readers must still see zero.
    append_inst(encode_itype(`OP_ORI, 5'd1, 5'd0, 16'h5555));
    append_inst(encode_itype(`OP_ORI, 5'd0, 5'd16, 16'h0001));
    append_inst(encode_rtype(5'd0, 5'd1, 5'd17, 5'd0, `FN_ADDU));
    append_inst(encode_rtype(5'd0, 5'd2, 5'd18, 5'd0, `FN_OR));
    // Back-to-back chain on r1, newest value wins.
    append_inst(encode_rtype(5'd1, 5'd1, 5'd1, 5'd0, `FN_ADDU));
    append_inst(encode_rtype(5'd1, 5'd1, 5'd1, 5'd0, `FN_ADDU));
    append_inst(encode_rtype(5'd1, 5'd1, 5'd1, 5'd0, `FN_ADDU));
    append_inst(encode_rtype(5'd1, 5'd3, 5'd19, 5'd0, `FN_XOR));
    append_inst(encode_rtype(5'd19, 5'd1, 5'd20, 5'd0, `FN_AND));
    repeat (MEM_WORDS - int'(fill_count)) begin
      append_inst(random_inst());
    end
  endtask

  // Architectural effect of one instruction, applied in program order.
  task automatic model_execute(input logic [31:0] word, output openmips_pkg::wb_t res);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sh;
    logic [15:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    op  = word[31:26];
    rs  = word[25:21];
    rt  = word[20:16];
    rd  = word[15:11];
    sh  = word[10:6];
    fn  = word[5:0];
    imm = word[15:0];
    a   = model_regs[rs];
    b   = model_regs[rt];
    res = '0;
    res.we    = 1'b1;
    res.waddr = rt;
    case (op)
      `OP_ORI:   res.wdata = a | {16'd0, imm};
      `OP_ANDI:  res.wdata = a & {16'd0, imm};
      `OP_XORI:  res.wdata = a ^ {16'd0, imm};
      `OP_LUI:   res.wdata = {imm, 16'd0};
      `OP_ADDIU: res.wdata = a + {{16{imm[15]}}, imm};
      `OP_SPECIAL: begin
        res.waddr = rd;
        case (fn)
          `FN_AND:  res.wdata = a & b;
          `FN_OR:   res.wdata = a | b;
          `FN_XOR:  res.wdata = a ^ b;
          `FN_NOR:  res.wdata = ~(a | b);
          `FN_ADDU: res.wdata = a + b;
          `FN_SUBU: res.wdata = a - b;
          // Differing signs decide by sign alone.
          `FN_SLT:  res.wdata = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
          `FN_SLL:  res.wdata = b << sh;
          `FN_SRL:  res.wdata = b >> sh;
          `FN_SRA:  res.wdata = b[31] ? ~(~b >> sh) : (b >> sh);  // Fills with ones.
          default:  res.we = 1'b0;
        endcase
      end
      default: res.we = 1'b0;
    endcase
    if (res.we && res.waddr != 5'd0) begin
      model_regs[res.waddr] = res.wdata;
    end
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they change.
  always @(negedge clk) begin
    openmips_pkg::wb_t exp;
    cycle = cycle + 1;
    if (rst_i) begin
      assert (ce_o === 1'b0 && addr_o === `RESET_PC && commit_o.we === 1'b0)
        else report_mismatch($sformatf("reset state ce_o=%b addr_o=%h commit_o.we=%b",
                                       ce_o, addr_o, commit_o.we));
      prev_ce = 1'b0;
    end else begin
      if (due_q.size() > 0 && due_q[0] == cycle) begin
        exp = exp_q.pop_front();
        void'(due_q.pop_front());
        assert (commit_o.we === exp.we)
          else report_mismatch($sformatf("commit we=%b, expected %b", commit_o.we, exp.we));
        if (exp.we) begin
          assert (commit_o.waddr === exp.waddr && commit_o.wdata === exp.wdata)
            else report_mismatch($sformatf("commit r%0d=%h, expected r%0d=%h",
                                           commit_o.waddr, commit_o.wdata,
                                           exp.waddr, exp.wdata));
        end
        retired = retired + 1;
      end else begin
        assert (commit_o.we === 1'b0)
          else report_mismatch($sformatf("commit of r%0d with no instruction due",
                                         commit_o.waddr));
      end
      if (ce_o) begin
        if (prev_ce) begin
          assert (addr_o === prev_addr + 32'd4)
            else report_mismatch($sformatf("addr_o=%h after %h", addr_o, prev_addr));
        end else begin
          assert (addr_o === `RESET_PC)
            else report_mismatch($sformatf("first fetch from %h", addr_o));
        end
        model_execute(inst_i, exp);
        exp_q.push_back(exp);
        due_q.push_back(cycle + 3);
        prev_addr = addr_o;
      end
      prev_ce = ce_o;
    end
  end

  initial begin
    int wait_cycles;
    rst_i      = 1'b1;
    seed       = 32'h8bc4;
    model_regs = '{default: 32'd0};
    load_program();
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    assert (ce_o === 1'b1 && addr_o === `RESET_PC)
      else report_mismatch($sformatf("after reset ce_o=%b addr_o=%h", ce_o, addr_o));
    wait_cycles = 0;
    while (retired < MEM_WORDS && wait_cycles < RUN_TIMEOUT) begin
      @(posedge clk);
      wait_cycles = wait_cycles + 1;
    end
    if (retired >= MEM_WORDS) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("timed out with %0d of %0d instructions retired", retired, MEM_WORDS);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== verilog/ex.sv ====
`timescale 1ns/1ps
`include "openmips_consts.svh"

module ex (
  input  openmips_pkg::id_ex_t id_ex_i,
  output openmips_pkg::wb_t    ex_res_o
);

  logic [31:0] logic_res;
  logic [31:0] shift_res;
  logic [31:0] arith_res;
  logic [31:0] result;

  always_comb begin
    case (id_ex_i.aluop)
      `ALUOP_AND: logic_res = id_ex_i.opnd1 & id_ex_i.opnd2;
      `ALUOP_OR:  logic_res = id_ex_i.opnd1 | id_ex_i.opnd2;
      `ALUOP_XOR: logic_res = id_ex_i.opnd1 ^ id_ex_i.opnd2;
      `ALUOP_NOR: logic_res = ~(id_ex_i.opnd1 | id_ex_i.opnd2);
      default:    logic_res = 32'd0;
    endcase
  end

  // Shifts act on operand 2, as in MIPS.
  always_comb begin
    case (id_ex_i.aluop)
      `ALUOP_SLL: shift_res = id_ex_i.opnd2 << id_ex_i.shamt;
      `ALUOP_SRL: shift_res = id_ex_i.opnd2 >> id_ex_i.shamt;
      `ALUOP_SRA: shift_res = $unsigned($signed(id_ex_i.opnd2) >>> id_ex_i.shamt);
      default:    shift_res = 32'd0;
    endcase
  end

  always_comb begin
    case (id_ex_i.aluop)
      `ALUOP_ADDU: arith_res = id_ex_i.opnd1 + id_ex_i.opnd2;
      `ALUOP_SUBU: arith_res = id_ex_i.opnd1 - id_ex_i.opnd2;
      `ALUOP_SLT: begin
        arith_res = {31'd0, $signed(id_ex_i.opnd1) < $signed(id_ex_i.opnd2)};
      end
      default:     arith_res = 32'd0;
    endcase
  end

  always_comb begin
    case (id_ex_i.alusel)
      `ALUSEL_LOGIC: result = logic_res;
      `ALUSEL_SHIFT: result = shift_res;
      `ALUSEL_ARITH: result = arith_res;
      default:       result = 32'd0;
    endcase
  end

  // Seen by decode in the same cycle, latched by the memory stage.
  always_comb begin
    ex_res_o.we    = id_ex_i.we;
    ex_res_o.waddr = id_ex_i.waddr;
    ex_res_o.wdata = result;
  end

endmodule

// ==== verilog/id.sv ====
`timescale 1ns/1ps
`include "openmips_consts.svh"

module id (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 ce_i,
  input  openmips_pkg::inst_u  inst_i,
  input  logic [31:0]          reg1_data_i,
  input  logic [31:0]          reg2_data_i,
  input  openmips_pkg::wb_t    ex_fwd_i,
  input  openmips_pkg::wb_t    mem_fwd_i,
  output logic [4:0]           reg1_addr_o,
  output logic [4:0]           reg2_addr_o,
  output logic                 reg1_re_o,
  output logic                 reg2_re_o,
  output openmips_pkg::id_ex_t id_ex_o
);

  logic [`ALUOP_W-1:0]  aluop;
  logic [`ALUSEL_W-1:0] alusel;
  logic                 wreg;
  logic [4:0]           waddr;
  logic                 use_imm;
  logic [31:0]          imm;
  logic [31:0]          opnd1;
  logic [31:0]          opnd2;

  // Newest value of a source register, nearest stage first.
  function automatic logic [31:0] resolve(
    input logic              re,
    input logic [4:0]        addr,
    input logic [31:0]       rf_data,
    input openmips_pkg::wb_t ex_fwd,
    input openmips_pkg::wb_t mem_fwd
  );
    if (!re || addr == 5'd0) begin
      return 32'd0;
    end else if (ex_fwd.we && ex_fwd.waddr == addr) begin
      return ex_fwd.wdata;
    end else if (mem_fwd.we && mem_fwd.waddr == addr) begin
      return mem_fwd.wdata;
    end
    return rf_data;  // Regfile already bypasses the write-back value.
  endfunction

  assign reg1_addr_o = inst_i.i_fmt.rs;
  assign reg2_addr_o = inst_i.i_fmt.rt;

  always_comb begin
    aluop     = `ALUOP_NOP;
    alusel    = `ALUSEL_NOP;
    wreg      = 1'b0;
    waddr     = inst_i.i_fmt.rt;
    use_imm   = 1'b1;
    imm       = {16'd0, inst_i.i_fmt.imm};  // Zero-extended unless changed.
    reg1_re_o = 1'b0;
    reg2_re_o = 1'b0;
    if (ce_i) begin
      case (inst_i.i_fmt.op)
        `OP_ORI: begin
          aluop     = `ALUOP_OR;
          alusel    = `ALUSEL_LOGIC;
          wreg      = 1'b1;
          reg1_re_o = 1'b1;
        end
        `OP_ANDI: begin
          aluop     = `ALUOP_AND;
          alusel    = `ALUSEL_LOGIC;
          wreg      = 1'b1;
          reg1_re_o = 1'b1;
        end
        `OP_XORI: begin
          aluop     = `ALUOP_XOR;
          alusel    = `ALUSEL_LOGIC;
          wreg      = 1'b1;
          reg1_re_o = 1'b1;
        end
        `OP_LUI: begin
          aluop  = `ALUOP_OR;
          alusel = `ALUSEL_LOGIC;
          wreg   = 1'b1;
          imm    = {inst_i.i_fmt.imm, 16'd0};  // Operand 1 stays zero.
        end
        `OP_ADDIU: begin
          aluop     = `ALUOP_ADDU;
          alusel    = `ALUSEL_ARITH;
          wreg      = 1'b1;
          reg1_re_o = 1'b1;
          imm       = {{16{inst_i.i_fmt.imm[15]}}, inst_i.i_fmt.imm};
        end
        `OP_SPECIAL: begin
          waddr     = inst_i.r_fmt.rd;
          wreg      = 1'b1;
          use_imm   = 1'b0;
          reg1_re_o = 1'b1;
          reg2_re_o = 1'b1;
          case (inst_i.r_fmt.funct)
            `FN_AND: begin
              aluop  = `ALUOP_AND;
              alusel = `ALUSEL_LOGIC;
            end
            `FN_OR: begin
              aluop  = `ALUOP_OR;
              alusel = `ALUSEL_LOGIC;
            end
            `FN_XOR: begin
              aluop  = `ALUOP_XOR;
              alusel = `ALUSEL_LOGIC;
            end
            `FN_NOR: begin
              aluop  = `ALUOP_NOR;
              alusel = `ALUSEL_LOGIC;
            end
            `FN_ADDU: begin
              aluop  = `ALUOP_ADDU;
              alusel = `ALUSEL_ARITH;
            end
            `FN_SUBU: begin
              aluop  = `ALUOP_SUBU;
              alusel = `ALUSEL_ARITH;
            end
            `FN_SLT: begin
              aluop  = `ALUOP_SLT;
              alusel = `ALUSEL_ARITH;
            end
            // Shifts take rt by shamt, rs is not read.
            `FN_SLL: begin
              aluop     = `ALUOP_SLL;
              alusel    = `ALUSEL_SHIFT;
              reg1_re_o = 1'b0;
            end
            `FN_SRL: begin
              aluop     = `ALUOP_SRL;
              alusel    = `ALUSEL_SHIFT;
              reg1_re_o = 1'b0;
            end
            `FN_SRA: begin
              aluop     = `ALUOP_SRA;
              alusel    = `ALUSEL_SHIFT;
              reg1_re_o = 1'b0;
            end
            default: begin
              wreg      = 1'b0;
              reg1_re_o = 1'b0;
              reg2_re_o = 1'b0;
            end
          endcase
        end
        default: ;  // Unknown opcode leaves a bubble.
      endcase
    end
  end

  assign opnd1 = resolve(reg1_re_o, reg1_addr_o, reg1_data_i, ex_fwd_i, mem_fwd_i);
  assign opnd2 = use_imm ? imm
                         : resolve(reg2_re_o, reg2_addr_o, reg2_data_i, ex_fwd_i, mem_fwd_i);

  // ID/EX register.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_o <= '0;
    end else begin
      id_ex_o.aluop  <= aluop;
      id_ex_o.alusel <= alusel;
      id_ex_o.opnd1  <= opnd1;
      id_ex_o.opnd2  <= opnd2;
      id_ex_o.shamt  <= inst_i.r_fmt.shamt;
      id_ex_o.we     <= wreg;
      id_ex_o.waddr  <= waddr;
    end
  end

endmodule

// ==== verilog/mem_wb.sv ====
`timescale 1ns/1ps

module mem_wb (
  input  logic              clk,
  input  logic              rst_i,
  input  openmips_pkg::wb_t ex_res_i,
  output openmips_pkg::wb_t mem_res_o,
  output openmips_pkg::wb_t wb_res_o
);

  // EX/MEM register. No loads, so the memory stage only carries the result.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mem_res_o <= '0;
    end else begin
      mem_res_o <= ex_res_i;
    end
  end

  // MEM/WB register, feeds the regfile write and the commit port.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_res_o <= '0;
    end else begin
      wb_res_o <= mem_res_o;
    end
  end

endmodule

// ==== verilog/openmips.sv ====
`timescale 1ns/1ps

module openmips (
  input  logic              clk,
  input  logic              rst_i,
  input  logic [31:0]       inst_i,
  output logic              ce_o,
  output logic [31:0]       addr_o,
  output openmips_pkg::wb_t commit_o
);

  logic [31:0]          pc;
  logic [4:0]           reg1_addr;
  logic [4:0]           reg2_addr;
  logic                 reg1_re;
  logic                 reg2_re;
  logic [31:0]          reg1_data;
  logic [31:0]          reg2_data;
  openmips_pkg::id_ex_t id_ex;
  openmips_pkg::wb_t    ex_res;
  openmips_pkg::wb_t    mem_res;

  assign addr_o = pc;

  pc_reg pc_reg0 (
    .clk   (clk),
    .rst_i (rst_i),
    .pc_o  (pc),
    .ce_o  (ce_o)
  );

  id id0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .ce_i        (ce_o),
    .inst_i      (inst_i),
    .reg1_data_i (reg1_data),
    .reg2_data_i (reg2_data),
    .ex_fwd_i    (ex_res),
    .mem_fwd_i   (mem_res),
    .reg1_addr_o (reg1_addr),
    .reg2_addr_o (reg2_addr),
    .reg1_re_o   (reg1_re),
    .reg2_re_o   (reg2_re),
    .id_ex_o     (id_ex)
  );

  regfile regfile0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .reg1_addr_i (reg1_addr),
    .reg2_addr_i (reg2_addr),
    .reg1_re_i   (reg1_re),
    .reg2_re_i   (reg2_re),
    .wr_i        (commit_o),  // Retiring write.
    .reg1_data_o (reg1_data),
    .reg2_data_o (reg2_data)
  );

  ex ex0 (
    .id_ex_i  (id_ex),
    .ex_res_o (ex_res)
  );

  mem_wb mem_wb0 (
    .clk       (clk),
    .rst_i     (rst_i),
    .ex_res_i  (ex_res),
    .mem_res_o (mem_res),
    .wb_res_o  (commit_o)
  );

endmodule

// ==== verilog/openmips_consts.svh ====
`ifndef OPENMIPS_CONSTS_SVH
`define OPENMIPS_CONSTS_SVH

// Major opcodes.
`define OP_SPECIAL   6'b000000
`define OP_ORI       6'b001101
`define OP_ANDI      6'b001100
`define OP_XORI      6'b001110
`define OP_LUI       6'b001111
`define OP_ADDIU     6'b001001

// Function field of SPECIAL.
`define FN_AND       6'b100100
`define FN_OR        6'b100101
`define FN_XOR       6'b100110
`define FN_NOR       6'b100111
`define FN_ADDU      6'b100001
`define FN_SUBU      6'b100011
`define FN_SLT       6'b101010
`define FN_SLL       6'b000000
`define FN_SRL       6'b000010
`define FN_SRA       6'b000011

// Result group picked in execute.
`define ALUSEL_W     3
`define ALUSEL_NOP   3'b000
`define ALUSEL_LOGIC 3'b001
`define ALUSEL_SHIFT 3'b010
`define ALUSEL_ARITH 3'b100

`define ALUOP_W      8
`define ALUOP_NOP    8'b00000000
`define ALUOP_AND    8'b00100100
`define ALUOP_OR     8'b00100101
`define ALUOP_XOR    8'b00100110
`define ALUOP_NOR    8'b00100111
`define ALUOP_SLL    8'b01111100
`define ALUOP_SRL    8'b00000010
`define ALUOP_SRA    8'b00000011
`define ALUOP_ADDU   8'b00100001
`define ALUOP_SUBU   8'b00100011
`define ALUOP_SLT    8'b00101010

`define RESET_PC     32'h0000_0000

`endif

// ==== verilog/openmips_pkg.sv ====
`include "openmips_consts.svh"

package openmips_pkg;

  // R-format view of an instruction word.
  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  // I-format view of the same word.
  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_u;

  // Decoded operation handed from decode to execute.
  typedef struct packed {
    logic [`ALUOP_W-1:0]  aluop;
    logic [`ALUSEL_W-1:0] alusel;
    logic [31:0]          opnd1;
    logic [31:0]          opnd2;
    logic [4:0]           shamt;
    logic                 we;
    logic [4:0]           waddr;
  } id_ex_t;

  // One register write, also used for forwarding and commit.
  typedef struct packed {
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } wb_t;

endpackage

// ==== verilog/pc_reg.sv ====
`timescale 1ns/1ps
`include "openmips_consts.svh"

module pc_reg (
  input  logic        clk,
  input  logic        rst_i,
  output logic [31:0] pc_o,
  output logic        ce_o
);

  // Fetch is enabled from the first edge after reset.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ce_o <= 1'b0;
    end else begin
      ce_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_o <= `RESET_PC;
    end else if (ce_o) begin
      pc_o <= pc_o + 32'd4;  // RESET_PC is fetched once before counting.
    end
  end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile (
  input  logic              clk,
  input  logic              rst_i,
  input  logic [4:0]        reg1_addr_i,
  input  logic [4:0]        reg2_addr_i,
  input  logic              reg1_re_i,
  input  logic              reg2_re_i,
  input  openmips_pkg::wb_t wr_i,
  output logic [31:0]       reg1_data_o,
  output logic [31:0]       reg2_data_o
);

  logic [31:0] regs [1:31];  // r0 has no storage.

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wr_i.we && wr_i.waddr != 5'd0) begin
      regs[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // One read port, with write-through of the value being written.
  function automatic logic [31:0] read_port(
    input logic       re,
    input logic [4:0] addr
  );
    if (!re || addr == 5'd0) begin
      return 32'd0;
    end else if (wr_i.we && wr_i.waddr == addr) begin
      return wr_i.wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    reg1_data_o = read_port(reg1_re_i, reg1_addr_i);
    reg2_data_o = read_port(reg2_re_i, reg2_addr_i);
  end

endmodule
